//--- build.f
+incdir+include
rtl/wisc_pkg.sv
rtl/extension_unit.sv
rtl/instr_decode.sv
rtl/register_file.sv
rtl/alu.sv
rtl/exec_core.sv
verif/exec_core_chk.sv
verif/exec_core_tb.sv

//--- Makefile
SIM := obj_dir/Vexec_core_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): build.f $(wildcard rtl/*.sv verif/*.sv include/*.svh)
	verilator --binary --timing --assert -f build.f --top-module exec_core_tb

# fails unless the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

//--- verif/exec_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core_tb;

   import wisc_pkg::*;

   localparam int RETIRE_TIMEOUT = 8;

   logic      clk;
   logic      rst;
   word_t     instr;
   logic      instr_valid;
   word_t     pc;
   logic      retire;
   logic      wr_en;
   reg_addr_t wr_reg;
   word_t     wr_data;

   // chained rows issue in the cycle right after the previous row
   word_t     tbl_instr[$];
   bit        tbl_chain[$];
   bit        tbl_wr_en[$];
   reg_addr_t tbl_wr_reg[$];
   word_t     tbl_wr_data[$];
   word_t     tbl_pc[$];

   int pass_cnt;
   int fail_cnt;
   int row_cnt;

   exec_core u_exec_core (
      .clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid),
      .pc(pc), .retire(retire), .wr_en(wr_en), .wr_reg(wr_reg), .wr_data(wr_data)
   );

   bind exec_core exec_core_chk u_exec_core_chk (
      .clk(clk), .rst(rst), .instr_valid(instr_valid), .retire(retire), .wr_en(wr_en)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic add_row(input word_t word, input bit chained, input bit we,
                          input reg_addr_t dest, input word_t data, input word_t npc);
      tbl_instr.push_back(word);
      tbl_chain.push_back(chained);
      tbl_wr_en.push_back(we);
      tbl_wr_reg.push_back(dest);
      tbl_wr_data.push_back(data);
      tbl_pc.push_back(npc);
   endtask

   task automatic load_table();
      // byte loads leave 0x853c in r1
      add_row(16'hC185, 1'b0, 1'b1, 3'd1, 16'hFF85, 16'h0002);
      add_row(16'h913C, 1'b1, 1'b1, 3'd1, 16'h853C, 16'h0004);
      // addi -3, subi -2, xori 0x1f, andni 0x1c
      add_row(16'h415D, 1'b1, 1'b1, 3'd2, 16'h8539, 16'h0006);
      add_row(16'h497E, 1'b0, 1'b1, 3'd3, 16'h7AC2, 16'h0008);
      add_row(16'h519F, 1'b0, 1'b1, 3'd4, 16'h8523, 16'h000A);
      add_row(16'h59BC, 1'b0, 1'b1, 3'd5, 16'h8520, 16'h000C);
      // rol 4, sll 3, ror 4, srl 5 on r1
      add_row(16'hA144, 1'b0, 1'b1, 3'd2, 16'h53C8, 16'h000E);
      add_row(16'hA963, 1'b1, 1'b1, 3'd3, 16'h29E0, 16'h0010);
      add_row(16'hB184, 1'b0, 1'b1, 3'd4, 16'hC853, 16'h0012);
      add_row(16'hB9A5, 1'b0, 1'b1, 3'd5, 16'h0429, 16'h0014);
      // branches on r0 zero, r3 positive, r1 negative
      add_row(16'h6004, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h001A);
      add_row(16'h6304, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h001C);
      add_row(16'h6104, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h001E);
      add_row(16'h6810, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0020);
      add_row(16'h6BFA, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h001C);
      add_row(16'h6908, 1'b1, 1'b0, 3'd0, 16'h0000, 16'h0026);
      add_row(16'h7008, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0028);
      add_row(16'h7308, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h002A);
      add_row(16'h7120, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h004C);
      add_row(16'h7802, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0050);
      add_row(16'h7BF0, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0042);
      add_row(16'h7902, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0044);
      // j back 32, jal forward 0x100, jr r7+4, jalr r3-16, jalr r7+2
      add_row(16'h27E0, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0026);
      add_row(16'h3100, 1'b0, 1'b1, 3'd7, 16'h0028, 16'h0128);
      add_row(16'h2F04, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h002C);
      add_row(16'h3BF0, 1'b0, 1'b1, 3'd7, 16'h002E, 16'h29D0);
      add_row(16'h3F02, 1'b0, 1'b1, 3'd7, 16'h29D2, 16'h0030);
      // r7 read right after the link write
      add_row(16'h47C1, 1'b1, 1'b1, 3'd6, 16'h29D3, 16'h0032);
      // st and ld retire without a write
      add_row(16'h8140, 1'b0, 1'b0, 3'd0, 16'h0000, 16'h0034);
      add_row(16'h8962, 1'b1, 1'b0, 3'd0, 16'h0000, 16'h0036);
   endtask

   task automatic issue(input int idx);
      instr       <= tbl_instr[idx];
      instr_valid <= 1'b1;
   endtask

   task automatic wait_retire(output bit seen);
      int n;
      seen = 1'b0;
      n = 0;
      while (!seen && n < RETIRE_TIMEOUT) begin
         @(negedge clk);
         seen = retire;
         n++;
      end
   endtask

   task automatic report(input string name, input bit ok);
      if (ok) begin
         pass_cnt++;
         $display("%s: ok", name);
      end else begin
         fail_cnt++;
         $display("%s: mismatch", name);
      end
   endtask

   // with no strobe the core stays idle at the reset pc
   task automatic check_idle();
      bit ok;
      ok = 1'b1;
      repeat (3) begin
         @(negedge clk);
         if (pc !== 16'h0000) begin
            $display("ERROR %0t: idle pc %h, expected 0000", $time, pc);
            ok = 1'b0;
         end
         if (retire !== 1'b0 || wr_en !== 1'b0) begin
            $display("ERROR %0t: retire %b wr_en %b while idle", $time, retire, wr_en);
            ok = 1'b0;
         end
      end
      report("reset idle", ok);
   endtask

   task automatic check_row(input int idx);
      bit seen;
      bit ok;
      wait_retire(seen);
      ok = 1'b1;
      if (!seen) begin
         $display("test %0d: the core did not retire instruction %h within %0d cycles",
                  idx, tbl_instr[idx], RETIRE_TIMEOUT);
         ok = 1'b0;
      end else begin
         if (wr_en !== tbl_wr_en[idx]) begin
            $display("ERROR %0t: test %0d wr_en %b, expected %b",
                     $time, idx, wr_en, tbl_wr_en[idx]);
            ok = 1'b0;
         end
         if (tbl_wr_en[idx] && wr_reg !== tbl_wr_reg[idx]) begin
            $display("ERROR %0t: test %0d wr_reg %0d, expected %0d",
                     $time, idx, wr_reg, tbl_wr_reg[idx]);
            ok = 1'b0;
         end
         if (tbl_wr_en[idx] && wr_data !== tbl_wr_data[idx]) begin
            $display("ERROR %0t: test %0d wr_data %h, expected %h",
                     $time, idx, wr_data, tbl_wr_data[idx]);
            ok = 1'b0;
         end
         if (pc !== tbl_pc[idx]) begin
            $display("ERROR %0t: test %0d pc %h, expected %h", $time, idx, pc, tbl_pc[idx]);
            ok = 1'b0;
         end
      end
      report($sformatf("test %0d instr %h", idx, tbl_instr[idx]), ok);
   endtask

   initial begin
      rst         <= 1'b1;
      instr       <= '0;
      instr_valid <= 1'b0;
      pass_cnt = 0;
      fail_cnt = 0;
      load_table();
      row_cnt = tbl_instr.size();

      @(posedge clk);
      // lbi r0 strobed in reset must neither retire, move pc nor write r0
      instr       <= 16'hC055;
      instr_valid <= 1'b1;
      repeat (3) @(posedge clk);
      rst         <= 1'b0;
      instr       <= '0;
      instr_valid <= 1'b0;
      check_idle();

      @(posedge clk);
      issue(0);
      for (int i = 0; i < row_cnt; i++) begin
         // accepting edge of row i
         @(posedge clk);
         if (i + 1 < row_cnt && tbl_chain[i + 1]) begin
            issue(i + 1);
         end else begin
            instr_valid <= 1'b0;
         end
         check_row(i);
         if (i + 1 < row_cnt && !tbl_chain[i + 1]) begin
            @(posedge clk);
            issue(i + 1);
         end
      end

      $display("%0d checks, %0d passed, %0d failed", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/exec_core_chk.sv
`timescale 1ns/1ns
`default_nettype none

module exec_core_chk (
   input logic clk,
   input logic rst,
   input logic instr_valid,
   input logic retire,
   input logic wr_en
);

   // retire drops unless another strobe was taken
   retire_one_cycle: assert property (
      @(posedge clk) disable iff (rst)
      retire && !instr_valid |=> !retire
   ) else $error("retire held without a new strobe");

   // a write is only reported alongside a retire
   wr_en_with_retire: assert property (
      @(posedge clk) disable iff (rst)
      wr_en |-> retire
   ) else $error("wr_en high without retire");

   // one cycle from strobe to retire, in both directions
   strobe_then_retire: assert property (
      @(posedge clk) disable iff (rst)
      instr_valid |=> retire
   ) else $error("strobe not followed by retire");

   retire_after_strobe: assert property (
      @(posedge clk) disable iff (rst)
      retire |-> $past(instr_valid)
   ) else $error("retire without a strobe one cycle earlier");

   quiet_in_reset: assert property (
      @(posedge clk)
      rst |=> !retire && !wr_en
   ) else $error("retire or wr_en during reset");

endmodule

`default_nettype wire

//--- rtl/exec_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "wisc_settings.svh"

module exec_core (
   input  logic                clk,
   input  logic                rst,
   input  wisc_pkg::word_t     instr,
   input  logic                instr_valid,
   output wisc_pkg::word_t     pc,
   output logic                retire,
   output logic                wr_en,
   output wisc_pkg::reg_addr_t wr_reg,
   output wisc_pkg::word_t     wr_data
);

   import wisc_pkg::*;

   reg_addr_t rd_a_sel;
   reg_addr_t rd_b_sel;
   reg_addr_t wr_sel;
   logic      reg_wr;
   alu_op_t   alu_op;
   br_kind_t  br_kind;
   word_t     immed;
   word_t     rs_val;
   word_t     rd_val;
   word_t     result;
   word_t     pc_plus2;
   word_t     next_pc;
   logic      rf_wr_en;
   logic      take_branch;

   instr_decode u_instr_decode (
      .instr(instr), .rd_a_sel(rd_a_sel), .rd_b_sel(rd_b_sel), .wr_sel(wr_sel),
      .reg_wr(reg_wr), .alu_op(alu_op), .br_kind(br_kind)
   );

   extension_unit u_extension_unit (.instr(instr), .immed(immed));

   register_file u_register_file (
      .clk(clk), .rst(rst), .rd_a_sel(rd_a_sel), .rd_b_sel(rd_b_sel),
      .wr_sel(wr_sel), .wr_en(rf_wr_en), .wr_data(result),
      .rd_a_val(rs_val), .rd_b_val(rd_val)
   );

   alu u_alu (
      .a(rs_val), .b(rd_val), .immed(immed), .pc_plus2(pc_plus2),
      .alu_op(alu_op), .result(result)
   );

   assign rf_wr_en = instr_valid & reg_wr;
   assign pc_plus2 = pc + word_t'(`WISC_INSTR_BYTES);

   // branch condition on rs
   always_comb begin
      case (br_kind)
         BR_EQZ:  take_branch = (rs_val == '0);
         BR_NEZ:  take_branch = (rs_val != '0);
         BR_LTZ:  take_branch = rs_val[$bits(word_t)-1];
         BR_GEZ:  take_branch = ~rs_val[$bits(word_t)-1];
         BR_REL:  take_branch = 1'b1;
         default: take_branch = 1'b0;
      endcase
   end

   // jr and jalr are absolute off rs, the rest pc-relative
   assign next_pc = (br_kind == BR_REG) ? rs_val + immed
                  : take_branch         ? pc_plus2 + immed
                  :                       pc_plus2;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc     <= word_t'(`WISC_RESET_PC);
         retire <= 1'b0;
         wr_en  <= 1'b0;
      end else begin
         retire <= instr_valid;
         wr_en  <= rf_wr_en;
         if (instr_valid) begin
            pc <= next_pc;
         end
      end
   end

   // write record, meaningful while retire is high
   always_ff @(posedge clk) begin
      wr_reg  <= wr_sel;
      wr_data <= result;
   end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
   input  wisc_pkg::word_t   a,
   input  wisc_pkg::word_t   b,
   input  wisc_pkg::word_t   immed,
   input  wisc_pkg::word_t   pc_plus2,
   input  wisc_pkg::alu_op_t alu_op,
   output wisc_pkg::word_t   result
);

   import wisc_pkg::*;

   localparam int W = $bits(word_t);

   logic [3:0]     shamt;
   logic [2*W-1:0] rot_left;
   logic [2*W-1:0] rot_right;

   // only the low four bits of the immediate count
   assign shamt = immed[3:0];

   // rotate by shifting the doubled word, then keep one half
   assign rot_left  = {a, a} << shamt;
   assign rot_right = {a, a} >> shamt;

   always_comb begin
      case (alu_op)
         ALU_ADD: begin
            result = a + immed;
         end

         // subi computes immediate minus rs
         ALU_RSUB: begin
            result = immed - a;
         end

         ALU_XOR: begin
            result = a ^ immed;
         end

         ALU_ANDN: begin
            result = a & ~immed;
         end

         ALU_ROL: begin
            result = rot_left[2*W-1:W];
         end

         ALU_SLL: begin
            result = a << shamt;
         end

         ALU_ROR: begin
            result = rot_right[W-1:0];
         end

         ALU_SRL: begin
            result = a >> shamt;
         end

         // lbi, immediate already sign extended
         ALU_PASSB: begin
            result = immed;
         end

         // b holds rs for slbi
         ALU_SLB: begin
            result = (b << 8) | word_t'(immed[7:0]);
         end

         ALU_LINK: begin
            result = pc_plus2;
         end

         default: begin
            result = '0;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "wisc_settings.svh"

module register_file (
   input  logic                clk,
   input  logic                rst,
   input  wisc_pkg::reg_addr_t rd_a_sel,
   input  wisc_pkg::reg_addr_t rd_b_sel,
   input  wisc_pkg::reg_addr_t wr_sel,
   input  logic                wr_en,
   input  wisc_pkg::word_t     wr_data,
   output wisc_pkg::word_t     rd_a_val,
   output wisc_pkg::word_t     rd_b_val
);

   import wisc_pkg::*;

   word_t regs [`WISC_REG_CNT];

   // every register comes out of reset as zero
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `WISC_REG_CNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // asynchronous reads
   // a write lands at the edge, so the next instruction sees it
   assign rd_a_val = regs[rd_a_sel];
   assign rd_b_val = regs[rd_b_sel];

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
   input  wisc_pkg::word_t     instr,
   output wisc_pkg::reg_addr_t rd_a_sel,
   output wisc_pkg::reg_addr_t rd_b_sel,
   output wisc_pkg::reg_addr_t wr_sel,
   output logic                reg_wr,
   output wisc_pkg::alu_op_t   alu_op,
   output wisc_pkg::br_kind_t  br_kind
);

   import wisc_pkg::*;

   localparam reg_addr_t LINK_REG = 3'd7;

   opcode_t   opcode;
   reg_addr_t rs_field;
   reg_addr_t rd_field;

   assign opcode   = instr[15:11];
   assign rs_field = instr[10:8];
   assign rd_field = instr[7:5];

   // port a always reads rs
   assign rd_a_sel = rs_field;

   // slbi needs rs on port b for the byte merge
   assign rd_b_sel = (opcode == OP_SLBI) ? rs_field : rd_field;

   always_comb begin
      reg_wr  = 1'b0;
      wr_sel  = rd_field;
      alu_op  = ALU_ADD;
      br_kind = BR_NONE;

      case (opcode)
         OP_ADDI:  begin reg_wr = 1'b1; alu_op = ALU_ADD;  end
         OP_SUBI:  begin reg_wr = 1'b1; alu_op = ALU_RSUB; end
         OP_XORI:  begin reg_wr = 1'b1; alu_op = ALU_XOR;  end
         OP_ANDNI: begin reg_wr = 1'b1; alu_op = ALU_ANDN; end
         OP_ROLI:  begin reg_wr = 1'b1; alu_op = ALU_ROL;  end
         OP_SLLI:  begin reg_wr = 1'b1; alu_op = ALU_SLL;  end
         OP_RORI:  begin reg_wr = 1'b1; alu_op = ALU_ROR;  end
         OP_SRLI:  begin reg_wr = 1'b1; alu_op = ALU_SRL;  end

         // byte loads write back into the rs field
         OP_LBI: begin
            reg_wr = 1'b1;
            wr_sel = rs_field;
            alu_op = ALU_PASSB;
         end
         OP_SLBI: begin
            reg_wr = 1'b1;
            wr_sel = rs_field;
            alu_op = ALU_SLB;
         end

         OP_BEQZ: br_kind = BR_EQZ;
         OP_BNEZ: br_kind = BR_NEZ;
         OP_BLTZ: br_kind = BR_LTZ;
         OP_BGEZ: br_kind = BR_GEZ;

         OP_J:  br_kind = BR_REL;
         OP_JR: br_kind = BR_REG;

         // link forms save pc+2 in r7
         OP_JAL: begin
            reg_wr  = 1'b1;
            wr_sel  = LINK_REG;
            alu_op  = ALU_LINK;
            br_kind = BR_REL;
         end
         OP_JALR: begin
            reg_wr  = 1'b1;
            wr_sel  = LINK_REG;
            alu_op  = ALU_LINK;
            br_kind = BR_REG;
         end

         // loads, stores, halt, nop and unknowns
         default: begin
            reg_wr  = 1'b0;
            br_kind = BR_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/extension_unit.sv
`timescale 1ns/1ns
`default_nettype none

module extension_unit (
   input  wisc_pkg::word_t instr,
   output wisc_pkg::word_t immed
);

   import wisc_pkg::*;

   opcode_t opcode;

   // candidate immediates, one per flavor
   word_t sext5;
   word_t zext5;
   word_t sext8;
   word_t zext8;
   word_t sext11;

   assign opcode = instr[15:11];

   assign sext5  = {{11{instr[4]}}, instr[4:0]};
   assign zext5  = {11'h000, instr[4:0]};
   assign sext8  = {{8{instr[7]}}, instr[7:0]};
   assign zext8  = {8'h00, instr[7:0]};
   assign sext11 = {{5{instr[10]}}, instr[10:0]};

   always_comb begin
      case (opcode)
         // pc-relative jumps carry the widest displacement
         OP_J,
         OP_JAL: begin
            immed = sext11;
         end

         OP_ADDI,
         OP_SUBI: begin
            immed = sext5;
         end

         // logic ops treat the field as a mask
         OP_XORI,
         OP_ANDNI: begin
            immed = zext5;
         end

         // low byte is merged under the shifted register
         OP_SLBI: begin
            immed = zext8;
         end

         OP_LBI,
         OP_JR,
         OP_JALR: begin
            immed = sext8;
         end

         // branch offsets
         OP_BEQZ,
         OP_BNEZ,
         OP_BLTZ,
         OP_BGEZ: begin
            immed = sext8;
         end

         // shifts, rotates, memory ops
         default: begin
            immed = sext5;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- rtl/wisc_pkg.sv
`default_nettype none

`include "wisc_settings.svh"

package wisc_pkg;

   typedef logic [`WISC_WORD_W-1:0]          word_t;
   typedef logic [$clog2(`WISC_REG_CNT)-1:0] reg_addr_t;
   typedef logic [4:0]                       opcode_t;
   typedef logic [3:0]                       alu_op_t;
   typedef logic [2:0]                       br_kind_t;

   // i-format 1, arithmetic and logic
   localparam opcode_t OP_ADDI  = 5'b01000;
   localparam opcode_t OP_SUBI  = 5'b01001;
   localparam opcode_t OP_XORI  = 5'b01010;
   localparam opcode_t OP_ANDNI = 5'b01011;
   // i-format 1, shifts and rotates
   localparam opcode_t OP_ROLI  = 5'b10100;
   localparam opcode_t OP_SLLI  = 5'b10101;
   localparam opcode_t OP_RORI  = 5'b10110;
   localparam opcode_t OP_SRLI  = 5'b10111;
   // i-format 2
   localparam opcode_t OP_LBI   = 5'b11000;
   localparam opcode_t OP_SLBI  = 5'b10010;
   localparam opcode_t OP_BEQZ  = 5'b01100;
   localparam opcode_t OP_BNEZ  = 5'b01101;
   localparam opcode_t OP_BLTZ  = 5'b01110;
   localparam opcode_t OP_BGEZ  = 5'b01111;
   localparam opcode_t OP_JR    = 5'b00101;
   localparam opcode_t OP_JALR  = 5'b00111;
   // j-format
   localparam opcode_t OP_J     = 5'b00100;
   localparam opcode_t OP_JAL   = 5'b00110;

   localparam alu_op_t ALU_ADD   = 4'd0;
   localparam alu_op_t ALU_RSUB  = 4'd1;
   localparam alu_op_t ALU_XOR   = 4'd2;
   localparam alu_op_t ALU_ANDN  = 4'd3;
   localparam alu_op_t ALU_ROL   = 4'd4;
   localparam alu_op_t ALU_SLL   = 4'd5;
   localparam alu_op_t ALU_ROR   = 4'd6;
   localparam alu_op_t ALU_SRL   = 4'd7;
   localparam alu_op_t ALU_PASSB = 4'd8;
   localparam alu_op_t ALU_SLB   = 4'd9;
   localparam alu_op_t ALU_LINK  = 4'd10;

   localparam br_kind_t BR_NONE = 3'd0;
   localparam br_kind_t BR_EQZ  = 3'd1;
   localparam br_kind_t BR_NEZ  = 3'd2;
   localparam br_kind_t BR_LTZ  = 3'd3;
   localparam br_kind_t BR_GEZ  = 3'd4;
   localparam br_kind_t BR_REL  = 3'd5;
   localparam br_kind_t BR_REG  = 3'd6;

endpackage

`default_nettype wire

//--- include/wisc_settings.svh
`ifndef WISC_SETTINGS_SVH
`define WISC_SETTINGS_SVH

// core sizing

// data and instruction word width
`define WISC_WORD_W 16

// architectural registers, r7 doubles as link register
`define WISC_REG_CNT 8

// reset vector
`define WISC_RESET_PC 16'h0000

// every instruction is one word, two bytes
`define WISC_INSTR_BYTES 2

`endif
